//--- compile.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/forward_unit.sv
hdl/alu.sv
hdl/regfile.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/cpu_core.sv
tb/tb_cpu_core.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/100ps --top-module tb_cpu_core \
    -f compile.f -o tb_cpu_core_sim \
    && ./obj_dir/tb_cpu_core_sim 2>&1 | tee sim.log

grep -qx "Result: PASSED" sim.log && exit 0 || exit 1

//--- tb/tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module tb_cpu_core
    import isa_pkg::*;
();

    typedef struct packed {
        word_t    inst;
        logic     wr;
        reg_idx_t dest;
        word_t    value;
    } prog_row_t;

    localparam word_t phys_reset  = `CPU_RESET_PC & `CPU_PHYS_MASK;
    // opcode 0x3f is not decoded
    localparam word_t unkept_word = 32'hFC00_0000;
    localparam int    drain_cycles = 8;

    logic       clk;
    logic       reset;
    logic       inst_req;
    word_t      inst_addr;
    word_t      inst_rdata;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    prog_row_t prog [$];
    int        check_errors;
    int        missing_errors;
    int        cycles;
    int        cycle_limit;
    word_t     held_addr;
    logic      held_req;

    cpu_core cpu_core_inst (
        .clk               (clk),
        .reset             (reset),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t rtype_word(funct_e fn, reg_idx_t rs, reg_idx_t rt,
                                         reg_idx_t rd, shamt_t sa);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype_word(opcode_e op, reg_idx_t rs, reg_idx_t rt,
                                         imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t fetch_word(word_t addr);
        int offset;
        offset = int'((addr - phys_reset) >> 2);
        if (offset >= 0 && offset < prog.size()) begin
            return prog[offset].inst;
        end
        return unkept_word;
    endfunction

    task automatic add_row(input word_t inst, input logic wr, input reg_idx_t dest,
                           input word_t value);
        prog_row_t row;
        row.inst = inst;
        row.wr = wr;
        row.dest = dest;
        row.value = value;
        prog.push_back(row);
    endtask

    // expected values follow the ALU rules in program order
    task automatic load_program();
        add_row(itype_word(op_addiu, 5'd0, 5'd1, 16'h0005), 1'b1, 5'd1, 32'h0000_0005);
        add_row(itype_word(op_addiu, 5'd0, 5'd2, 16'hFFFE), 1'b1, 5'd2, 32'hFFFF_FFFE);
        add_row(itype_word(op_ori, 5'd0, 5'd3, 16'h8001), 1'b1, 5'd3, 32'h0000_8001);
        add_row(itype_word(op_lui, 5'd0, 5'd4, 16'h1234), 1'b1, 5'd4, 32'h1234_0000);
        add_row(itype_word(op_slti, 5'd2, 5'd5, 16'h0001), 1'b1, 5'd5, 32'h0000_0001);
        add_row(itype_word(op_slti, 5'd1, 5'd6, 16'hFFFF), 1'b1, 5'd6, 32'h0000_0000);
        add_row(itype_word(op_sltiu, 5'd1, 5'd7, 16'hFFFF), 1'b1, 5'd7, 32'h0000_0001);
        add_row(itype_word(op_sltiu, 5'd2, 5'd8, 16'h0003), 1'b1, 5'd8, 32'h0000_0000);
        add_row(itype_word(op_andi, 5'd2, 5'd9, 16'hF0F0), 1'b1, 5'd9, 32'h0000_F0F0);
        add_row(itype_word(op_xori, 5'd3, 5'd10, 16'hFFFF), 1'b1, 5'd10, 32'h0000_7FFE);
        add_row(rtype_word(fn_addu, 5'd1, 5'd4, 5'd11, 5'd0), 1'b1, 5'd11, 32'h1234_0005);
        add_row(rtype_word(fn_subu, 5'd1, 5'd2, 5'd12, 5'd0), 1'b1, 5'd12, 32'h0000_0007);
        add_row(rtype_word(fn_and, 5'd3, 5'd2, 5'd13, 5'd0), 1'b1, 5'd13, 32'h0000_8000);
        add_row(rtype_word(fn_or, 5'd4, 5'd3, 5'd14, 5'd0), 1'b1, 5'd14, 32'h1234_8001);
        add_row(rtype_word(fn_xor, 5'd4, 5'd2, 5'd15, 5'd0), 1'b1, 5'd15, 32'hEDCB_FFFE);
        add_row(rtype_word(fn_nor, 5'd1, 5'd3, 5'd16, 5'd0), 1'b1, 5'd16, 32'hFFFF_7FFA);
        add_row(rtype_word(fn_slt, 5'd2, 5'd1, 5'd17, 5'd0), 1'b1, 5'd17, 32'h0000_0001);
        add_row(rtype_word(fn_sltu, 5'd2, 5'd1, 5'd18, 5'd0), 1'b1, 5'd18, 32'h0000_0000);
        add_row(rtype_word(fn_sll, 5'd0, 5'd3, 5'd19, 5'd4), 1'b1, 5'd19, 32'h0008_0010);
        add_row(rtype_word(fn_srl, 5'd0, 5'd2, 5'd20, 5'd28), 1'b1, 5'd20, 32'h0000_000F);
        add_row(rtype_word(fn_sra, 5'd0, 5'd2, 5'd21, 5'd1), 1'b1, 5'd21, 32'hFFFF_FFFF);
        // dependency chain at distances 1, 2 and 3
        add_row(itype_word(op_addiu, 5'd0, 5'd22, 16'h0010), 1'b1, 5'd22, 32'h0000_0010);
        add_row(rtype_word(fn_addu, 5'd22, 5'd22, 5'd23, 5'd0), 1'b1, 5'd23, 32'h0000_0020);
        add_row(rtype_word(fn_subu, 5'd23, 5'd22, 5'd24, 5'd0), 1'b1, 5'd24, 32'h0000_0010);
        add_row(rtype_word(fn_addu, 5'd24, 5'd22, 5'd25, 5'd0), 1'b1, 5'd25, 32'h0000_0020);
        add_row(itype_word(op_addiu, 5'd22, 5'd22, 16'h0001), 1'b1, 5'd22, 32'h0000_0011);
        add_row(rtype_word(fn_addu, 5'd22, 5'd23, 5'd26, 5'd0), 1'b1, 5'd26, 32'h0000_0031);
        add_row(itype_word(op_addiu, 5'd26, 5'd26, 16'h0002), 1'b1, 5'd26, 32'h0000_0033);
        add_row(itype_word(op_addiu, 5'd26, 5'd26, 16'h0003), 1'b1, 5'd26, 32'h0000_0036);
        // $26 sits in EX, MEM and WB at once here
        add_row(rtype_word(fn_addu, 5'd26, 5'd0, 5'd27, 5'd0), 1'b1, 5'd27, 32'h0000_0036);
        // newer $26 in MEM beats the older one in WB
        add_row(rtype_word(fn_addu, 5'd0, 5'd26, 5'd25, 5'd0), 1'b1, 5'd25, 32'h0000_0036);
        // write to $0 shows in the trace but the register stays zero
        add_row(itype_word(op_addiu, 5'd0, 5'd0, 16'h0007), 1'b1, 5'd0, 32'h0000_0007);
        add_row(rtype_word(fn_addu, 5'd0, 5'd1, 5'd28, 5'd0), 1'b1, 5'd28, 32'h0000_0005);
        add_row(unkept_word, 1'b0, 5'd0, 32'h0000_0000);
        add_row(rtype_word(fn_or, 5'd0, 5'd0, 5'd29, 5'd0), 1'b1, 5'd29, 32'h0000_0000);
        // lw $1, 0($0)
        add_row(32'h8C01_0000, 1'b0, 5'd0, 32'h0000_0000);
        add_row(itype_word(op_addiu, 5'd29, 5'd30, 16'hFFFF), 1'b1, 5'd30, 32'hFFFF_FFFF);
        add_row(rtype_word(fn_sra, 5'd0, 5'd15, 5'd31, 5'd4), 1'b1, 5'd31, 32'hFEDC_BFFF);
        // lui and ori with the other sign of immediate
        add_row(itype_word(op_lui, 5'd0, 5'd9, 16'h8765), 1'b1, 5'd9, 32'h8765_0000);
        add_row(itype_word(op_ori, 5'd9, 5'd10, 16'h00F0), 1'b1, 5'd10, 32'h8765_00F0);
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected,
                             input reg_idx_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic check_wen(input string name, input logic [3:0] expected,
                             input logic [3:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            check_errors++;
        end
    endtask

    task automatic wait_for_write(output logic found);
        found = 1'b0;
        while (!found && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
            if (debug_wb_rf_wen != 4'b0000) begin
                found = 1'b1;
            end
        end
    endtask

    // instruction memory with one cycle of read latency
    always @(negedge clk) begin
        if (held_req) begin
            inst_rdata = fetch_word(held_addr);
        end
        held_addr = inst_addr;
        held_req = inst_req;
    end

    initial begin
        logic  found;
        string name;
        word_t exp_pc;
        int    i;

        reset = 1'b1;
        inst_rdata = '0;
        held_addr = '0;
        held_req = 1'b0;
        check_errors = 0;
        missing_errors = 0;
        cycles = 0;
        load_program();
        cycle_limit = prog.size() + 20;

        repeat (5) @(negedge clk);
        reset = 1'b0;

        while (!inst_req && cycles < cycle_limit) begin
            @(negedge clk);
            cycles++;
        end
        check_word("first fetch address", phys_reset, inst_addr);

        for (i = 0; i < prog.size(); i++) begin
            if (prog[i].wr) begin
                wait_for_write(found);
                if (!found) begin
                    $display("timeout: register writes from row %0d on never retired", i);
                    missing_errors++;
                    break;
                end
                name = $sformatf("row %0d", i);
                exp_pc = `CPU_RESET_PC + word_t'(i) * `CPU_PC_STEP;
                check_wen({name, " wen"}, 4'b1111, debug_wb_rf_wen);
                check_word({name, " pc"}, exp_pc, debug_wb_pc);
                check_reg({name, " wnum"}, prog[i].dest, debug_wb_rf_wnum);
                check_word({name, " wdata"}, prog[i].value, debug_wb_rf_wdata);
            end
        end

        // unkept words past the table must stay silent
        if (missing_errors == 0) begin
            repeat (drain_cycles) begin
                @(negedge clk);
                if (debug_wb_rf_wen != 4'b0000) begin
                    $display("unexpected register write retired at pc %h", debug_wb_pc);
                    check_errors++;
                end
            end
        end

        $display("errors: %0d wrong values, %0d missing writes", check_errors, missing_errors);
        if (check_errors == 0 && missing_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       inst_req,
    output word_t      inst_addr,
    input  word_t      inst_rdata,
    output word_t      debug_wb_pc,
    output logic [3:0] debug_wb_rf_wen,
    output reg_idx_t   debug_wb_rf_wnum,
    output word_t      debug_wb_rf_wdata
);

    logic     if_valid;
    word_t    if_pc;
    word_t    if_inst;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_raw;
    word_t    rt_raw;
    fwd_t     fwd_ex;
    fwd_t     fwd_mem;
    fwd_t     fwd_wb;
    logic     ex_valid;
    id_ex_t   ex_bundle;
    logic     wb_valid;
    wb_t      wb_bundle;
    logic     rf_wen;

    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .reset      (reset),
        .inst_req   (inst_req),
        .inst_addr  (inst_addr),
        .inst_rdata (inst_rdata),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_inst    (if_inst)
    );

    decode_stage decode_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .if_valid  (if_valid),
        .if_pc     (if_pc),
        .if_inst   (if_inst),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rs_raw    (rs_raw),
        .rt_raw    (rt_raw),
        .fwd_ex    (fwd_ex),
        .fwd_mem   (fwd_mem),
        .fwd_wb    (fwd_wb),
        .ex_valid  (ex_valid),
        .ex_bundle (ex_bundle)
    );

    regfile regfile_inst (
        .clk    (clk),
        .rs_idx (rs_idx),
        .rt_idx (rt_idx),
        .rs_raw (rs_raw),
        .rt_raw (rt_raw),
        .wen    (rf_wen),
        .w_idx  (wb_bundle.dest),
        .w_data (wb_bundle.result)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .reset     (reset),
        .ex_valid  (ex_valid),
        .ex_bundle (ex_bundle),
        .fwd_ex    (fwd_ex),
        .fwd_mem   (fwd_mem),
        .fwd_wb    (fwd_wb),
        .wb_valid  (wb_valid),
        .wb_bundle (wb_bundle)
    );

    // retire
    assign rf_wen = wb_valid & wb_bundle.reg_write;

    assign debug_wb_pc       = wb_bundle.pc;
    assign debug_wb_rf_wen   = {4{rf_wen}};
    assign debug_wb_rf_wnum  = wb_bundle.dest;
    assign debug_wb_rf_wdata = wb_bundle.result;

endmodule

`default_nettype wire

//--- hdl/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   ex_valid,
    input  id_ex_t ex_bundle,
    output fwd_t   fwd_ex,
    output fwd_t   fwd_mem,
    output fwd_t   fwd_wb,
    output logic   wb_valid,
    output wb_t    wb_bundle
);

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_result;
    wb_t        ex_res;
    logic [1:0] valid_q;
    wb_t        stage_q [2];

    assign alu_a = ex_bundle.a_is_shamt ? {27'b0, ex_bundle.shamt} : ex_bundle.rs_val;
    assign alu_b = ex_bundle.b_is_imm ? ex_bundle.imm : ex_bundle.rt_val;

    alu alu_inst (
        .op     (ex_bundle.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result)
    );

    assign ex_res = '{
        pc:        ex_bundle.pc,
        reg_write: ex_bundle.reg_write,
        dest:      ex_bundle.dest,
        result:    alu_result
    };

    // slot 0 is EX/MEM, slot 1 is MEM/WB
    // nothing happens in MEM any more, results just ride through
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 2'b00;
        end else begin
            valid_q <= {valid_q[0], ex_valid};
        end
    end

    always_ff @(posedge clk) begin
        stage_q[0] <= ex_res;
        stage_q[1] <= stage_q[0];
    end

    assign fwd_ex  = '{valid: ex_valid, reg_write: ex_res.reg_write,
                       dest: ex_res.dest, value: ex_res.result};
    assign fwd_mem = '{valid: valid_q[0], reg_write: stage_q[0].reg_write,
                       dest: stage_q[0].dest, value: stage_q[0].result};
    assign fwd_wb  = '{valid: valid_q[1], reg_write: stage_q[1].reg_write,
                       dest: stage_q[1].dest, value: stage_q[1].result};

    assign wb_valid  = valid_q[1];
    assign wb_bundle = stage_q[1];

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     if_valid,
    input  word_t    if_pc,
    input  word_t    if_inst,
    output reg_idx_t rs_idx,
    output reg_idx_t rt_idx,
    input  word_t    rs_raw,
    input  word_t    rt_raw,
    input  fwd_t     fwd_ex,
    input  fwd_t     fwd_mem,
    input  fwd_t     fwd_wb,
    output logic     ex_valid,
    output id_ex_t   ex_bundle
);

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rd;
    imm16_t   imm16;
    alu_op_e  alu_op;
    logic     kept;
    logic     is_rtype;
    logic     zero_ext;
    word_t    rs_val;
    word_t    rt_val;
    id_ex_t   next;

    assign opcode = opcode_e'(if_inst[31:26]);
    assign rs_idx = if_inst[25:21];
    assign rt_idx = if_inst[20:16];
    assign rd     = if_inst[15:11];
    assign imm16  = if_inst[15:0];
    assign funct  = funct_e'(if_inst[5:0]);

    always_comb begin
        alu_op = alu_add;
        kept = 1'b1;
        case (opcode)
            op_special: begin
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    default: kept = 1'b0;
                endcase
            end
            op_addiu: alu_op = alu_add;
            op_slti:  alu_op = alu_slt;
            op_sltiu: alu_op = alu_sltu;
            op_andi:  alu_op = alu_and;
            op_ori:   alu_op = alu_or;
            op_xori:  alu_op = alu_xor;
            // lui shifts the raw immediate in the alu
            op_lui:   alu_op = alu_lui;
            default:  kept = 1'b0;
        endcase
    end

    assign is_rtype = (opcode == op_special);
    // logical immediates are zero extended, sltiu stays signed
    assign zero_ext = opcode inside {op_andi, op_ori, op_xori};

    forward_unit rs_fwd (
        .src     (rs_idx),
        .raw     (rs_raw),
        .fwd_ex  (fwd_ex),
        .fwd_mem (fwd_mem),
        .fwd_wb  (fwd_wb),
        .value   (rs_val)
    );

    forward_unit rt_fwd (
        .src     (rt_idx),
        .raw     (rt_raw),
        .fwd_ex  (fwd_ex),
        .fwd_mem (fwd_mem),
        .fwd_wb  (fwd_wb),
        .value   (rt_val)
    );

    always_comb begin
        next.pc = if_pc;
        next.rs_val = rs_val;
        next.rt_val = rt_val;
        next.imm = zero_ext ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
        next.shamt = if_inst[10:6];
        next.alu_op = alu_op;
        next.b_is_imm = ~is_rtype;
        // only sll/srl/sra are kept, all take shamt
        next.a_is_shamt = alu_op inside {alu_sll, alu_srl, alu_sra};
        next.reg_write = kept;
        next.dest = is_rtype ? rd : rt_idx;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= if_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_bundle <= next;
    end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module fetch_stage
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output logic  inst_req,
    output word_t inst_addr,
    input  word_t inst_rdata,
    output logic  if_valid,
    output word_t if_pc,
    output word_t if_inst
);

    logic  req_q;
    word_t pc;
    logic  pend_valid;
    word_t pend_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            pc <= `CPU_RESET_PC;
            pend_valid <= 1'b0;
            if_valid <= 1'b0;
        end else begin
            req_q <= 1'b1;
            if (req_q) begin
                pc <= pc + `CPU_PC_STEP;
            end
            pend_valid <= req_q;
            if_valid <= pend_valid;
        end
    end

    // pc of the word coming back next cycle
    always_ff @(posedge clk) begin
        pend_pc <= pc;
        if_pc <= pend_pc;
        if_inst <= inst_rdata;
    end

    assign inst_req = req_q;

    // kseg0 and kseg1 both map onto the low 512 MB
    assign inst_addr = (pc[31:30] == 2'b10) ? (pc & `CPU_PHYS_MASK) : pc;

endmodule

`default_nettype wire

//--- hdl/regfile.sv
`timescale 1ns/100ps
`default_nettype none
`include "cpu_consts.svh"

module regfile
    import isa_pkg::*;
(
    input  logic     clk,
    input  reg_idx_t rs_idx,
    input  reg_idx_t rt_idx,
    output word_t    rs_raw,
    output word_t    rt_raw,
    input  logic     wen,
    input  reg_idx_t w_idx,
    input  word_t    w_data
);

    word_t regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (wen && (w_idx != '0)) begin
            regs[w_idx] <= w_data;
        end
    end

    // entry 0 is never written, so force the read
    assign rs_raw = (rs_idx == '0) ? '0 : regs[rs_idx];
    assign rt_raw = (rt_idx == '0) ? '0 : regs[rt_idx];

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
    import isa_pkg::*;
(
    input  alu_op_e op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] sa;

    // shift amount comes in on a
    assign sa = a[4:0];

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
            alu_sltu: result = {31'b0, a < b};
            alu_sll:  result = b << sa;
            alu_srl:  result = b >> sa;
            alu_sra:  result = word_t'($signed(b) >>> sa);
            alu_lui:  result = {b[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/forward_unit.sv
`timescale 1ns/100ps
`default_nettype none

module forward_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  reg_idx_t src,
    input  word_t    raw,
    input  fwd_t     fwd_ex,
    input  fwd_t     fwd_mem,
    input  fwd_t     fwd_wb,
    output word_t    value
);

    logic hit_ex;
    logic hit_mem;
    logic hit_wb;

    // $0 is never forwarded
    assign hit_ex  = fwd_ex.valid && fwd_ex.reg_write && (fwd_ex.dest == src) && (src != '0);
    assign hit_mem = fwd_mem.valid && fwd_mem.reg_write && (fwd_mem.dest == src) && (src != '0);
    assign hit_wb  = fwd_wb.valid && fwd_wb.reg_write && (fwd_wb.dest == src) && (src != '0);

    // newest producer wins
    always_comb begin
        if (hit_ex) begin
            value = fwd_ex.value;
        end else if (hit_mem) begin
            value = fwd_mem.value;
        end else if (hit_wb) begin
            value = fwd_wb.value;
        end else begin
            value = raw;
        end
    end

endmodule

`default_nettype wire

//--- hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // ID/EX register contents
    typedef struct packed {
        word_t    pc;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        shamt_t   shamt;
        alu_op_e  alu_op;
        logic     b_is_imm;
        logic     a_is_shamt;
        logic     reg_write;
        reg_idx_t dest;
    } id_ex_t;

    // EX/MEM and MEM/WB contents
    typedef struct packed {
        word_t    pc;
        logic     reg_write;
        reg_idx_t dest;
        word_t    result;
    } wb_t;

    // one producer seen by the forward units
    typedef struct packed {
        logic     valid;
        logic     reg_write;
        reg_idx_t dest;
        word_t    value;
    } fwd_t;

endpackage

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [15:0] imm16_t;

    // primary opcodes still decoded
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_addiu   = 6'h09,
        op_slti    = 6'h0a,
        op_sltiu   = 6'h0b,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_xori    = 6'h0e,
        op_lui     = 6'h0f
    } opcode_e;

    // function field under op_special
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

endpackage

`default_nettype wire

//--- hdl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// virtual reset vector, in kseg1
`define CPU_RESET_PC 32'hBFC00000
`define CPU_PC_STEP 32'd4

`define CPU_NUM_REGS 32

// clears the segment bits of kseg0/kseg1
`define CPU_PHYS_MASK 32'h1FFFFFFF

`endif
